//--- verif/coreStim.txt
# name stallOk rdy instValid inst pc predTaken, then the expected outputs of that cycle:
# retireValid retirePc retireRd retireValue redirectValid redirectPc (ignored when valid is 0)
reset    0 1 0 00000000 00000000 0 0 00000000 00 00000000 0 00000000
reset    1 1 0 00000000 00000000 0 0 00000000 00 00000000 0 00000000
aluChain 0 1 1 12328093 00000100 0 0 00000000 00 00000000 0 00000000
aluChain 0 1 1 FFD08113 00000104 0 0 00000000 00 00000000 0 00000000
aluChain 0 1 1 002081B3 00000108 0 0 00000000 00 00000000 0 00000000
aluChain 0 1 1 40308233 0000010C 0 1 00000100 01 00000123 0 00000000
aluChain 0 1 1 40425293 00000110 0 1 00000104 02 00000120 0 00000000
aluChain 0 1 1 00122333 00000114 0 1 00000108 03 00000243 0 00000000
aluChain 0 1 1 001233B3 00000118 0 1 0000010C 04 FFFFFEE0 0 00000000
aluChain 0 1 1 ABCDE0B7 0000011C 0 1 00000110 05 FFFFFFEE 0 00000000
aluChain 0 1 1 00001117 00000120 0 1 00000114 06 00000001 0 00000000
aluChain 0 1 1 00508013 00000124 0 1 00000118 07 00000000 0 00000000
aluChain 0 1 1 0FF0C193 00000128 0 1 0000011C 01 ABCDE000 0 00000000
branch   0 1 1 00318863 0000012C 1 1 00000120 02 00001120 0 00000000
branch   0 1 1 00109463 0000013C 0 1 00000124 00 00000000 0 00000000
branch   0 1 1 0240E063 00000140 0 1 00000128 03 ABCDE0FF 0 00000000
branch   0 1 1 05500313 00000144 0 1 0000012C 00 00000000 0 00000000
branch   0 1 1 06600393 00000148 0 1 0000013C 00 00000000 0 00000000
branch   0 1 1 07700093 0000014C 0 1 00000140 00 00000000 1 00000160
branch   0 1 1 007302B3 00000160 0 0 00000000 00 00000000 0 00000000
branch   1 1 1 FC70D0E3 00000164 1 0 00000000 00 00000000 0 00000000
branch   0 1 1 01100113 00000124 0 0 00000000 00 00000000 0 00000000
branch   0 1 1 02200193 00000128 0 1 00000160 05 00000001 0 00000000
branch   0 1 1 03300213 0000012C 0 1 00000164 00 00000000 1 00000168
jump     0 1 1 1000036F 00000168 0 0 00000000 00 00000000 0 00000000
jump     0 1 1 04400393 0000016C 0 0 00000000 00 00000000 0 00000000
jump     1 1 0 00000000 00000000 0 0 00000000 00 00000000 0 00000000
jump     0 1 0 00000000 00000000 0 1 00000168 06 0000016C 1 00000268
jump     0 1 1 035303E7 00000268 1 0 00000000 00 00000000 0 00000000
jump     0 1 1 00100313 0000026C 0 0 00000000 00 00000000 0 00000000
jump     1 1 0 00000000 00000000 0 0 00000000 00 00000000 0 00000000
jump     0 1 0 00000000 00000000 0 1 00000268 07 0000026C 1 000001A0
memStall 0 1 1 01030093 000001A0 0 0 00000000 00 00000000 0 00000000
memStall 0 1 1 0080A103 000001A4 0 0 00000000 00 00000000 0 00000000
memStall 0 1 1 0020A223 000001A8 0 0 00000000 00 00000000 0 00000000
memStall 0 1 1 000001FF 000001AC 0 1 000001A0 01 0000017C 0 00000000
memStall 0 0 1 00310233 000001B0 0 1 000001A4 00 00000000 0 00000000
memStall 0 0 1 00310233 000001B0 0 0 00000000 00 00000000 0 00000000
memStall 0 1 1 00310233 000001B0 0 0 00000000 00 00000000 0 00000000
memStall 0 1 0 00000000 00000000 0 1 000001A8 00 00000000 0 00000000
memStall 0 1 0 00000000 00000000 0 1 000001AC 00 00000000 0 00000000
memStall 0 1 0 00000000 00000000 0 1 000001B0 04 ABCDF21F 0 00000000
memStall 0 1 0 00000000 00000000 0 0 00000000 00 00000000 0 00000000
memStall 1 1 0 00000000 00000000 0 0 00000000 00 00000000 0 00000000

//--- vlog.f
common/rvPkg.sv
decode/instDecoder.sv
execute/regFile.sv
execute/aluUnit.sv
result/resultStage.sv
design/rvCoreTop.sv
verif/rvCoreTb.sv

//--- verif/rvCoreTb.sv
`timescale 1ns/1ns

module rvCoreTb;

    localparam int RESET_CYCLES = 16;

    logic           clk;
    logic           rst;
    logic           rdy;
    logic           instValid;
    rvPkg::instT    inst;
    rvPkg::addrT    pc;
    logic           predTaken;
    logic           retireValid;
    rvPkg::addrT    retirePc;
    rvPkg::regNameT retireRd;
    rvPkg::dataT    retireValue;
    logic           redirectValid;
    rvPkg::addrT    redirectPc;

    // One entry per stimulus line.
    string          testName [$];
    logic           stallOk [$];
    logic           rdyIn [$];
    logic           validIn [$];
    rvPkg::instT    instIn [$];
    rvPkg::addrT    pcIn [$];
    logic           predIn [$];
    logic           expRetire [$];
    rvPkg::addrT    expRetirePc [$];
    rvPkg::regNameT expRetireRd [$];
    rvPkg::dataT    expRetireValue [$];
    logic           expRedirect [$];
    rvPkg::addrT    expRedirectPc [$];

    integer seed;
    int     cycleCount;
    int     cycleLimit;

    rvCoreTop #(.REG_COUNT(32)) u_dut (
        .clk(clk), .rst(rst), .rdy(rdy), .instValid(instValid), .inst(inst),
        .pc(pc), .predTaken(predTaken), .retireValid(retireValid),
        .retirePc(retirePc), .retireRd(retireRd), .retireValue(retireValue),
        .redirectValid(redirectValid), .redirectPc(redirectPc)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stopOnFailure(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic compareBit(input string test, input string field,
                              input logic expected, input logic actual);
        if (actual !== expected) begin
            stopOnFailure($sformatf("ERROR %s %s expected %b actual %b",
                                    test, field, expected, actual));
        end
    endtask

    task automatic compareAddr(input string test, input string field,
                               input rvPkg::addrT expected, input rvPkg::addrT actual);
        if (actual !== expected) begin
            stopOnFailure($sformatf("ERROR %s %s expected %h actual %h",
                                    test, field, expected, actual));
        end
    endtask

    task automatic compareRegName(input string test, input rvPkg::regNameT expected,
                                  input rvPkg::regNameT actual);
        if (actual !== expected) begin
            stopOnFailure($sformatf("ERROR %s retireRd expected %0d actual %0d",
                                    test, expected, actual));
        end
    endtask

    task automatic compareData(input string test, input rvPkg::dataT expected,
                               input rvPkg::dataT actual);
        if (actual !== expected) begin
            stopOnFailure($sformatf("ERROR %s retireValue expected %h actual %h",
                                    test, expected, actual));
        end
    endtask

    task automatic checkRetire(input string test, input logic expValid,
                               input rvPkg::addrT expPc, input rvPkg::regNameT expRd,
                               input rvPkg::dataT expValue);
        compareBit(test, "retireValid", expValid, retireValid);
        if (expValid) begin
            compareAddr(test, "retirePc", expPc, retirePc);
            compareRegName(test, expRd, retireRd);
            compareData(test, expValue, retireValue);
        end
    endtask

    task automatic checkRedirect(input string test, input logic expValid,
                                 input rvPkg::addrT expPc);
        compareBit(test, "redirectValid", expValid, redirectValid);
        if (expValid) begin
            compareAddr(test, "redirectPc", expPc, redirectPc);
        end
    endtask

    task automatic loadStim();
        int          fd;
        int          code;
        int          ch;
        logic        done;
        string       name;
        logic [31:0] fStall, fRdy, fValid, fInst, fPc, fPred;
        logic [31:0] fRv, fRpc, fRd, fVal, fDv, fDpc;
        fd = $fopen("verif/coreStim.txt", "r");
        if (fd == 0) begin
            stopOnFailure("Could not open the stimulus file verif/coreStim.txt");
        end
        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, "%s", name);
            if (code != 1) begin
                done = 1'b1;
            end else if (name == "#") begin
                ch = $fgetc(fd);
                while (ch != 10 && ch != -1) begin
                    ch = $fgetc(fd);
                end
            end else begin
                code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h",
                               fStall, fRdy, fValid, fInst, fPc, fPred,
                               fRv, fRpc, fRd, fVal, fDv, fDpc);
                if (code != 12) begin
                    stopOnFailure($sformatf("Stimulus line %s has missing fields", name));
                end
                testName.push_back(name);
                stallOk.push_back(fStall[0]);
                rdyIn.push_back(fRdy[0]);
                validIn.push_back(fValid[0]);
                instIn.push_back(fInst);
                pcIn.push_back(fPc);
                predIn.push_back(fPred[0]);
                expRetire.push_back(fRv[0]);
                expRetirePc.push_back(fRpc);
                expRetireRd.push_back(fRd[4:0]);
                expRetireValue.push_back(fVal);
                expRedirect.push_back(fDv[0]);
                expRedirectPc.push_back(fDpc);
            end
        end
        $fclose(fd);
    endtask

    initial begin
        cycleCount = 0;
        forever begin
            @(posedge clk);
            cycleCount++;
            if (cycleLimit > 0 && cycleCount > cycleLimit) begin
                stopOnFailure($sformatf("Timeout: no end of test after %0d cycles",
                                        cycleCount));
            end
        end
    end

    initial begin
        int extra;
        seed       = 32'h415f_52ec;
        cycleLimit = 0;
        rst        = 1'b1;
        rdy        = 1'b0;
        instValid  = 1'b0;
        inst       = '0;
        pc         = '0;
        predTaken  = 1'b0;
        loadStim();
        cycleLimit = 2 * testName.size() + 50;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < testName.size(); i++) begin
            // Extra frozen cycles only before lines that expect no retire.
            if (stallOk[i]) begin
                extra = $unsigned($random(seed)) % 4;
                repeat (extra) begin
                    rdy       <= 1'b0;
                    instValid <= 1'b0;
                    @(negedge clk);
                    compareBit(testName[i], "retireValid", 1'b0, retireValid);
                    compareBit(testName[i], "redirectValid", 1'b0, redirectValid);
                    @(posedge clk);
                end
            end
            rdy       <= rdyIn[i];
            instValid <= validIn[i];
            inst      <= instIn[i];
            pc        <= pcIn[i];
            predTaken <= predIn[i];
            @(negedge clk);
            checkRetire(testName[i], expRetire[i], expRetirePc[i], expRetireRd[i],
                        expRetireValue[i]);
            checkRedirect(testName[i], expRedirect[i], expRedirectPc[i]);
            @(posedge clk);
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- design/rvCoreTop.sv
`timescale 1ns/1ns

module rvCoreTop #(
    parameter int REG_COUNT = 32
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           rdy,
    input  logic           instValid,
    input  rvPkg::instT    inst,
    input  rvPkg::addrT    pc,
    input  logic           predTaken,
    output logic           retireValid,
    output rvPkg::addrT    retirePc,
    output rvPkg::regNameT retireRd,
    output rvPkg::dataT    retireValue,
    output logic           redirectValid,
    output rvPkg::addrT    redirectPc
);

    logic           squash;
    logic           decValid;
    rvPkg::opT      decOp;
    rvPkg::regNameT decRs1;
    rvPkg::regNameT decRs2;
    rvPkg::regNameT decRd;
    rvPkg::dataT    decImm;
    rvPkg::addrT    decPc;
    logic           decPredTaken;
    rvPkg::dataT    rs1Value;
    rvPkg::dataT    rs2Value;
    logic           exValid;
    rvPkg::opT      exOp;
    rvPkg::regNameT exRd;
    rvPkg::dataT    exValue;
    rvPkg::addrT    exPc;
    rvPkg::addrT    exTarget;
    logic           exTaken;
    logic           exPredTaken;
    logic           wrEn;
    rvPkg::regNameT wrRd;
    rvPkg::dataT    wrValue;

    instDecoder uInstDecoder (
        .clk(clk), .rst(rst), .rdy(rdy), .squash(squash),
        .instValid(instValid), .inst(inst), .pc(pc), .predTaken(predTaken),
        .decValid(decValid), .decOp(decOp), .decRs1(decRs1), .decRs2(decRs2),
        .decRd(decRd), .decImm(decImm), .decPc(decPc), .decPredTaken(decPredTaken)
    );

    regFile #(.REG_COUNT(REG_COUNT)) uRegFile (
        .clk(clk), .rst(rst), .wrEn(wrEn), .wrRd(wrRd), .wrValue(wrValue),
        .rdRs1(decRs1), .rdRs2(decRs2), .rs1Value(rs1Value), .rs2Value(rs2Value)
    );

    aluUnit uAluUnit (
        .clk(clk), .rst(rst), .rdy(rdy), .squash(squash), .decValid(decValid),
        .decOp(decOp), .decRd(decRd), .decRs1(decRs1), .decRs2(decRs2),
        .decImm(decImm), .decPc(decPc), .decPredTaken(decPredTaken),
        .rs1Value(rs1Value), .rs2Value(rs2Value),
        .exValid(exValid), .exOp(exOp), .exRd(exRd), .exValue(exValue),
        .exPc(exPc), .exTarget(exTarget), .exTaken(exTaken), .exPredTaken(exPredTaken)
    );

    resultStage uResultStage (
        .clk(clk), .rst(rst), .rdy(rdy), .exValid(exValid), .exOp(exOp),
        .exRd(exRd), .exValue(exValue), .exPc(exPc), .exTarget(exTarget),
        .exTaken(exTaken), .exPredTaken(exPredTaken),
        .wrEn(wrEn), .wrRd(wrRd), .wrValue(wrValue),
        .retireValid(retireValid), .retirePc(retirePc), .retireRd(retireRd),
        .retireValue(retireValue), .redirectValid(redirectValid),
        .redirectPc(redirectPc), .squash(squash)
    );

endmodule

//--- result/resultStage.sv
`timescale 1ns/1ns

module resultStage (
    input  logic           clk,
    input  logic           rst,
    input  logic           rdy,
    input  logic           exValid,
    input  rvPkg::opT      exOp,
    input  rvPkg::regNameT exRd,
    input  rvPkg::dataT    exValue,
    input  rvPkg::addrT    exPc,
    input  rvPkg::addrT    exTarget,
    input  logic           exTaken,
    input  logic           exPredTaken,
    output logic           wrEn,
    output rvPkg::regNameT wrRd,
    output rvPkg::dataT    wrValue,
    output logic           retireValid,
    output rvPkg::addrT    retirePc,
    output rvPkg::regNameT retireRd,
    output rvPkg::dataT    retireValue,
    output logic           redirectValid,
    output rvPkg::addrT    redirectPc,
    output logic           squash
);

    logic doesWrite;
    logic isBranch;
    logic mispredict;
    logic keepLive;
    logic squashHold;

    assign doesWrite = rvPkg::writesReg(exOp) && exRd != '0;
    assign isBranch  = exOp inside {rvPkg::BEQ, rvPkg::BNE, rvPkg::BLT,
                                    rvPkg::BGE, rvPkg::BLTU, rvPkg::BGEU};

    // JALR target is unknown at fetch, so it always redirects.
    assign mispredict = (isBranch && exTaken != exPredTaken) ||
                        (exOp == rvPkg::JAL && !exPredTaken) ||
                        (exOp == rvPkg::JALR);

    assign keepLive = exValid && !squash;
    assign wrEn     = rdy && keepLive && doesWrite;
    assign wrRd     = exRd;
    assign wrValue  = exValue;
    // A pending squash survives stall cycles until the next ready edge.
    assign squash   = redirectValid || squashHold;

    always_ff @(posedge clk) begin
        if (rst) begin
            retireValid   <= 1'b0;
            retirePc      <= '0;
            retireRd      <= '0;
            retireValue   <= '0;
            redirectValid <= 1'b0;
            redirectPc    <= '0;
            squashHold    <= 1'b0;
        end else if (rdy) begin
            retireValid   <= keepLive;
            retirePc      <= exPc;
            retireRd      <= doesWrite ? exRd : '0;
            retireValue   <= doesWrite ? exValue : '0;
            redirectValid <= keepLive && mispredict;
            redirectPc    <= exTaken ? exTarget : exPc + 32'd4;
            squashHold    <= 1'b0;
        end else begin
            retireValid   <= 1'b0;
            redirectValid <= 1'b0;
            squashHold    <= squash;
        end
    end

    redirectHasRetire: assert property (@(posedge clk) disable iff (rst)
        redirectValid |-> retireValid)
        else $error("redirect without a retiring instruction");

endmodule

//--- execute/aluUnit.sv
`timescale 1ns/1ns

module aluUnit (
    input  logic           clk,
    input  logic           rst,
    input  logic           rdy,
    input  logic           squash,
    input  logic           decValid,
    input  rvPkg::opT      decOp,
    input  rvPkg::regNameT decRd,
    input  rvPkg::regNameT decRs1,
    input  rvPkg::regNameT decRs2,
    input  rvPkg::dataT    decImm,
    input  rvPkg::addrT    decPc,
    input  logic           decPredTaken,
    input  rvPkg::dataT    rs1Value,
    input  rvPkg::dataT    rs2Value,
    output logic           exValid,
    output rvPkg::opT      exOp,
    output rvPkg::regNameT exRd,
    output rvPkg::dataT    exValue,
    output rvPkg::addrT    exPc,
    output rvPkg::addrT    exTarget,
    output logic           exTaken,
    output logic           exPredTaken
);

    logic        fwdValid;
    rvPkg::dataT opA;
    rvPkg::dataT opB;
    rvPkg::dataT valueNext;
    rvPkg::addrT targetNext;
    logic        takenNext;

    // The previous result is still in flight to the register file.
    assign fwdValid = exValid && exRd != '0 && rvPkg::writesReg(exOp);
    assign opA = (fwdValid && exRd == decRs1) ? exValue : rs1Value;
    assign opB = (fwdValid && exRd == decRs2) ? exValue : rs2Value;

    always_comb begin
        case (decOp)
            rvPkg::LUI:   valueNext = decImm;
            rvPkg::AUIPC: valueNext = decPc + decImm;
            rvPkg::JAL,
            rvPkg::JALR:  valueNext = decPc + 32'd4;
            rvPkg::ADDI:  valueNext = opA + decImm;
            rvPkg::SLTI:  valueNext = {31'd0, $signed(opA) < $signed(decImm)};
            rvPkg::SLTIU: valueNext = {31'd0, opA < decImm};
            rvPkg::XORI:  valueNext = opA ^ decImm;
            rvPkg::ORI:   valueNext = opA | decImm;
            rvPkg::ANDI:  valueNext = opA & decImm;
            rvPkg::SLLI:  valueNext = opA << decImm[4:0];
            rvPkg::SRLI:  valueNext = opA >> decImm[4:0];
            rvPkg::SRAI:  valueNext = $signed(opA) >>> decImm[4:0];
            rvPkg::ADD:   valueNext = opA + opB;
            rvPkg::SUB:   valueNext = opA - opB;
            rvPkg::SLL:   valueNext = opA << opB[4:0];
            rvPkg::SLT:   valueNext = {31'd0, $signed(opA) < $signed(opB)};
            rvPkg::SLTU:  valueNext = {31'd0, opA < opB};
            rvPkg::XOR:   valueNext = opA ^ opB;
            rvPkg::SRL:   valueNext = opA >> opB[4:0];
            rvPkg::SRA:   valueNext = $signed(opA) >>> opB[4:0];
            rvPkg::OR:    valueNext = opA | opB;
            rvPkg::AND:   valueNext = opA & opB;
            default:      valueNext = '0;
        endcase
    end

    always_comb begin
        case (decOp)
            rvPkg::BEQ:  takenNext = (opA == opB);
            rvPkg::BNE:  takenNext = (opA != opB);
            rvPkg::BLT:  takenNext = ($signed(opA) < $signed(opB));
            rvPkg::BGE:  takenNext = ($signed(opA) >= $signed(opB));
            rvPkg::BLTU: takenNext = (opA < opB);
            rvPkg::BGEU: takenNext = (opA >= opB);
            rvPkg::JAL,
            rvPkg::JALR: takenNext = 1'b1;
            default:     takenNext = 1'b0;
        endcase
    end

    // Jump register target drops bit 0.
    assign targetNext = (decOp == rvPkg::JALR) ? ((opA + decImm) & ~32'd1) : (decPc + decImm);

    always_ff @(posedge clk) begin
        if (rst) begin
            exValid     <= 1'b0;
            exOp        <= rvPkg::NOP;
            exRd        <= '0;
            exValue     <= '0;
            exPc        <= '0;
            exTarget    <= '0;
            exTaken     <= 1'b0;
            exPredTaken <= 1'b0;
        end else if (rdy) begin
            exValid     <= decValid && !squash;
            exOp        <= decOp;
            exRd        <= decRd;
            exValue     <= valueNext;
            exPc        <= decPc;
            exTarget    <= targetNext;
            exTaken     <= takenNext;
            exPredTaken <= decPredTaken;
        end
    end

    exOpKnown: assert property (@(posedge clk) disable iff (rst)
        exValid |-> !$isunknown(exOp))
        else $error("exOp unknown while exValid is high");

endmodule

//--- execute/regFile.sv
`timescale 1ns/1ns

module regFile #(
    parameter int REG_COUNT = 32
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           wrEn,
    input  rvPkg::regNameT wrRd,
    input  rvPkg::dataT    wrValue,
    input  rvPkg::regNameT rdRs1,
    input  rvPkg::regNameT rdRs2,
    output rvPkg::dataT    rs1Value,
    output rvPkg::dataT    rs2Value
);

    rvPkg::dataT regs [REG_COUNT];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrRd != '0) begin
            regs[wrRd] <= wrValue;
        end
    end

    // x0 reads zero; a same-cycle write wins over the stored value.
    assign rs1Value = (rdRs1 == '0) ? '0 :
                      (wrEn && wrRd == rdRs1) ? wrValue : regs[rdRs1];

    assign rs2Value = (rdRs2 == '0) ? '0 :
                      (wrEn && wrRd == rdRs2) ? wrValue : regs[rdRs2];

endmodule

//--- decode/instDecoder.sv
`timescale 1ns/1ns

module instDecoder (
    input  logic           clk,
    input  logic           rst,
    input  logic           rdy,
    input  logic           squash,
    input  logic           instValid,
    input  rvPkg::instT    inst,
    input  rvPkg::addrT    pc,
    input  logic           predTaken,
    output logic           decValid,
    output rvPkg::opT      decOp,
    output rvPkg::regNameT decRs1,
    output rvPkg::regNameT decRs2,
    output rvPkg::regNameT decRd,
    output rvPkg::dataT    decImm,
    output rvPkg::addrT    decPc,
    output logic           decPredTaken
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic        funct7b5;
    logic [3:0]  funct;
    rvPkg::opT   opNext;
    rvPkg::dataT immNext;

    assign opcode   = inst[6:0];
    assign funct3   = inst[14:12];
    assign funct7b5 = inst[30];
    assign funct    = {funct7b5, funct3};

    // Immediate by instruction format.
    always_comb begin
        case (opcode)
            rvPkg::OPC_LUI, rvPkg::OPC_AUIPC: begin
                immNext = {inst[31:12], 12'b0};
            end
            rvPkg::OPC_JAL: begin
                immNext = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            rvPkg::OPC_BRANCH: begin
                immNext = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            rvPkg::OPC_JALR, rvPkg::OPC_OPIMM, rvPkg::OPC_LOAD: begin
                immNext = {{21{inst[31]}}, inst[30:20]};
            end
            rvPkg::OPC_STORE: begin
                immNext = {{21{inst[31]}}, inst[30:25], inst[11:7]};
            end
            default: begin
                immNext = '0;
            end
        endcase
    end

    always_comb begin
        opNext = rvPkg::NOP;
        case (opcode)
            rvPkg::OPC_LUI:   opNext = rvPkg::LUI;
            rvPkg::OPC_AUIPC: opNext = rvPkg::AUIPC;
            rvPkg::OPC_JAL:   opNext = rvPkg::JAL;
            rvPkg::OPC_JALR:  opNext = rvPkg::JALR;
            rvPkg::OPC_BRANCH: begin
                case (funct3)
                    3'b000:  opNext = rvPkg::BEQ;
                    3'b001:  opNext = rvPkg::BNE;
                    3'b100:  opNext = rvPkg::BLT;
                    3'b101:  opNext = rvPkg::BGE;
                    3'b110:  opNext = rvPkg::BLTU;
                    3'b111:  opNext = rvPkg::BGEU;
                    default: opNext = rvPkg::NOP;
                endcase
            end
            rvPkg::OPC_LOAD: begin
                case (funct3)
                    3'b000:  opNext = rvPkg::LB;
                    3'b001:  opNext = rvPkg::LH;
                    3'b010:  opNext = rvPkg::LW;
                    3'b100:  opNext = rvPkg::LBU;
                    3'b101:  opNext = rvPkg::LHU;
                    default: opNext = rvPkg::NOP;
                endcase
            end
            rvPkg::OPC_STORE: begin
                case (funct3)
                    3'b000:  opNext = rvPkg::SB;
                    3'b001:  opNext = rvPkg::SH;
                    3'b010:  opNext = rvPkg::SW;
                    default: opNext = rvPkg::NOP;
                endcase
            end
            rvPkg::OPC_OPIMM: begin
                // Bit 30 is an immediate bit here, except on shifts.
                case (funct3)
                    3'b000:  opNext = rvPkg::ADDI;
                    3'b010:  opNext = rvPkg::SLTI;
                    3'b011:  opNext = rvPkg::SLTIU;
                    3'b100:  opNext = rvPkg::XORI;
                    3'b110:  opNext = rvPkg::ORI;
                    3'b111:  opNext = rvPkg::ANDI;
                    3'b001:  opNext = funct7b5 ? rvPkg::NOP : rvPkg::SLLI;
                    3'b101:  opNext = funct7b5 ? rvPkg::SRAI : rvPkg::SRLI;
                    default: opNext = rvPkg::NOP;
                endcase
            end
            rvPkg::OPC_OP: begin
                case (funct)
                    4'b0000: opNext = rvPkg::ADD;
                    4'b1000: opNext = rvPkg::SUB;
                    4'b0001: opNext = rvPkg::SLL;
                    4'b0010: opNext = rvPkg::SLT;
                    4'b0011: opNext = rvPkg::SLTU;
                    4'b0100: opNext = rvPkg::XOR;
                    4'b0101: opNext = rvPkg::SRL;
                    4'b1101: opNext = rvPkg::SRA;
                    4'b0110: opNext = rvPkg::OR;
                    4'b0111: opNext = rvPkg::AND;
                    default: opNext = rvPkg::NOP;
                endcase
            end
            default: opNext = rvPkg::NOP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            decValid     <= 1'b0;
            decOp        <= rvPkg::NOP;
            decRs1       <= '0;
            decRs2       <= '0;
            decRd        <= '0;
            decImm       <= '0;
            decPc        <= '0;
            decPredTaken <= 1'b0;
        end else if (rdy) begin
            decValid     <= instValid && !squash;
            decOp        <= opNext;
            decRs1       <= inst[19:15];
            decRs2       <= inst[24:20];
            decRd        <= inst[11:7];
            decImm       <= immNext;
            decPc        <= pc;
            decPredTaken <= predTaken;
        end
    end

    // Wrong-path work must not enter the pipeline.
    squashDropsFetch: assert property (@(posedge clk) disable iff (rst)
        (rdy && squash) |=> !decValid)
        else $error("decValid set after a squash");

endmodule

//--- common/rvPkg.sv
package rvPkg;

    typedef logic [31:0] instT;
    typedef logic [31:0] addrT;
    typedef logic [31:0] dataT;
    typedef logic [4:0]  regNameT;

    // One value per decoded operation.
    typedef enum logic [5:0] {
        NOP,
        LUI,
        AUIPC,
        JAL,
        JALR,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        LB,
        LH,
        LW,
        LBU,
        LHU,
        SB,
        SH,
        SW,
        ADDI,
        SLTI,
        SLTIU,
        XORI,
        ORI,
        ANDI,
        SLLI,
        SRLI,
        SRAI,
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND
    } opT;

    // RV32I major opcodes.
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    // Branches, memory ops and NOP leave the register file alone.
    function automatic logic writesReg(opT op);
        logic writes;
        case (op)
            NOP, BEQ, BNE, BLT, BGE, BLTU, BGEU: begin
                writes = 1'b0;
            end
            LB, LH, LW, LBU, LHU, SB, SH, SW: begin
                writes = 1'b0;
            end
            default: begin
                writes = 1'b1;
            end
        endcase
        return writes;
    endfunction

endpackage
